/* design/spu_alu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_alu_top #(
    parameter int DATA_BITS = spu_pkg::DEFAULT_DATA_BITS,
    parameter int LATENCY   = spu_pkg::DEFAULT_LATENCY
) (
    input  var logic                 clk,
    input  var logic                 reset,

    input  var logic                 s_valid,
    input  var spu_pkg::spu_op_t     s_op,
    input  var logic                 s_clear,
    input  var logic [DATA_BITS-1:0] s_a,
    input  var logic [DATA_BITS-1:0] s_b,
    output var logic                 s_ready,

    output var logic                 m_valid,
    output var logic [DATA_BITS-1:0] m_data,
    input  var logic                 m_ready
);

    import spu_pkg::*;

    localparam type data_t = logic [DATA_BITS-1:0];

    logic      cke;
    logic      sel_not;
    logic      sel_logic;
    logic      sel_add;
    logic_fn_t fn;
    spu_op_t   tag_q;       // opcode at the pipeline output
    data_t     res_not;
    data_t     res_logic;
    data_t     res_add;

    // ------------------------------
    // handshake
    // ------------------------------

    // whole pipeline stalls while a result waits downstream
    assign cke     = !m_valid || m_ready;
    assign s_ready = cke;

    // ------------------------------
    // opcode decode
    // ------------------------------

    always_comb begin
        sel_not   = 1'b0;
        sel_logic = 1'b0;
        sel_add   = 1'b0;
        fn        = fn_and;
        case (s_op)
            op_not: sel_not = 1'b1;
            op_and: begin
                sel_logic = 1'b1;
                fn        = fn_and;
            end
            op_or: begin
                sel_logic = 1'b1;
                fn        = fn_or;
            end
            op_xor: begin
                sel_logic = 1'b1;
                fn        = fn_xor;
            end
            op_add: sel_add = 1'b1;
            default: ;  // no operator picked
        endcase
    end

    // ------------------------------
    // operand stages
    // ------------------------------

    spu_stage_if #(.data_t(data_t)) stage_not ();
    spu_stage_if #(.data_t(data_t)) stage_logic ();
    spu_stage_if #(.data_t(data_t)) stage_add ();

    assign stage_not.cke     = cke;
    assign stage_not.data    = s_a;
    assign stage_not.clear   = s_clear;
    assign stage_not.valid   = s_valid && sel_not;

    assign stage_logic.cke   = cke;
    assign stage_logic.data  = s_a;
    assign stage_logic.clear = s_clear;
    assign stage_logic.valid = s_valid && sel_logic;

    assign stage_add.cke     = cke;
    assign stage_add.data    = s_a;
    assign stage_add.clear   = s_clear;
    assign stage_add.valid   = s_valid && sel_add;

    // ------------------------------
    // operators
    // ------------------------------

    spu_op_not #(
        .LATENCY (LATENCY),
        .data_t  (data_t)
    ) u_op_not (
        .clk    (clk),
        .reset  (reset),
        .stage  (stage_not),
        .m_data (res_not)
    );

    spu_op_logic #(
        .LATENCY (LATENCY),
        .data_t  (data_t)
    ) u_op_logic (
        .clk    (clk),
        .reset  (reset),
        .stage  (stage_logic),
        .b      (s_b),
        .fn     (fn),
        .m_data (res_logic)
    );

    spu_op_add #(
        .LATENCY (LATENCY),
        .data_t  (data_t)
    ) u_op_add (
        .clk    (clk),
        .reset  (reset),
        .stage  (stage_add),
        .b      (s_b),
        .m_data (res_add)
    );

    // ------------------------------
    // side channels
    // ------------------------------

    // a cycle with cke high and no s_valid shifts in a bubble
    spu_delay #(
        .DEPTH       (LATENCY),
        .payload_t   (logic),
        .RESET_VALUE (1'b0)
    ) u_valid_delay (
        .clk      (clk),
        .reset    (reset),
        .cke      (cke),
        .in_data  (s_valid),
        .out_data (m_valid)
    );

    spu_delay #(
        .DEPTH       (LATENCY),
        .payload_t   (spu_op_t),
        .RESET_VALUE (op_not)
    ) u_tag_delay (
        .clk      (clk),
        .reset    (reset),
        .cke      (cke),
        .in_data  (s_op),
        .out_data (tag_q)
    );

    // result select by delayed tag
    always_comb begin
        case (tag_q)
            op_not:                m_data = res_not;
            op_and, op_or, op_xor: m_data = res_logic;
            op_add:                m_data = res_add;
            default:               m_data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/spu_delay.sv */
`timescale 1ns/1ps
`default_nettype none

// cke gated shift register
// out_data is in_data from DEPTH cke-high edges earlier
module spu_delay #(
    parameter int       DEPTH       = 1,
    parameter type      payload_t   = logic,
    parameter payload_t RESET_VALUE = payload_t'(0)
) (
    input  var logic     clk,
    input  var logic     reset,
    input  var logic     cke,
    input  var payload_t in_data,
    output var payload_t out_data
);

    generate
        if (DEPTH == 0) begin : g_bypass
            // zero latency
            assign out_data = in_data;
        end else begin : g_pipe
            payload_t stages [DEPTH];

            always_ff @(posedge clk) begin
                if (reset) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stages[i] <= RESET_VALUE;
                    end
                end else if (cke) begin
                    stages[0] <= in_data;
                    for (int i = 1; i < DEPTH; i++) begin
                        stages[i] <= stages[i-1];   // shift toward output
                    end
                end
            end

            assign out_data = stages[DEPTH-1];
        end
    endgenerate

endmodule

`default_nettype wire

/* design/spu_op_add.sv */
`timescale 1ns/1ps
`default_nettype none

// wrapping adder
// carry out is dropped so the sum keeps the data width
module spu_op_add #(
    parameter int  LATENCY = spu_pkg::DEFAULT_LATENCY,
    parameter type data_t  = logic [spu_pkg::DEFAULT_DATA_BITS-1:0]
) (
    input  var logic      clk,
    input  var logic      reset,
    spu_stage_if.operator stage,
    input  var data_t     b,
    output var data_t     m_data
);

    data_t sum;
    data_t result;

    // ------------------------------
    // operation
    // ------------------------------

    assign sum = stage.data + b;    // modulo 2**width

    always_comb begin
        if (stage.clear && stage.valid) begin
            result = '1;
        end else begin
            result = sum;
        end
    end

    // ------------------------------
    // result pipeline
    // ------------------------------

    spu_delay #(
        .DEPTH     (LATENCY),
        .payload_t (data_t)
    ) u_result_delay (
        .clk      (clk),
        .reset    (reset),
        .cke      (stage.cke),
        .in_data  (result),
        .out_data (m_data)
    );

endmodule

`default_nettype wire

/* design/spu_op_logic.sv */
`timescale 1ns/1ps
`default_nettype none

// and / or / xor of the stage data with b
module spu_op_logic #(
    parameter int  LATENCY = spu_pkg::DEFAULT_LATENCY,
    parameter type data_t  = logic [spu_pkg::DEFAULT_DATA_BITS-1:0]
) (
    input  var logic               clk,
    input  var logic               reset,
    spu_stage_if.operator          stage,
    input  var data_t              b,
    input  var spu_pkg::logic_fn_t fn,
    output var data_t              m_data
);

    import spu_pkg::*;

    data_t result;

    // ------------------------------
    // operation
    // ------------------------------

    always_comb begin
        if (stage.clear && stage.valid) begin
            result = '1;
        end else begin
            case (fn)
                fn_and:  result = stage.data & b;
                fn_or:   result = stage.data | b;
                fn_xor:  result = stage.data ^ b;
                default: result = '0;           // unused code
            endcase
        end
    end

    // ------------------------------
    // result pipeline
    // ------------------------------

    spu_delay #(
        .DEPTH     (LATENCY),
        .payload_t (data_t)
    ) u_result_delay (
        .clk      (clk),
        .reset    (reset),
        .cke      (stage.cke),
        .in_data  (result),
        .out_data (m_data)
    );

endmodule

`default_nettype wire

/* design/spu_op_not.sv */
`timescale 1ns/1ps
`default_nettype none

// bitwise not of the stage data
module spu_op_not #(
    parameter int  LATENCY = spu_pkg::DEFAULT_LATENCY,
    parameter type data_t  = logic [spu_pkg::DEFAULT_DATA_BITS-1:0]
) (
    input  var logic      clk,
    input  var logic      reset,
    spu_stage_if.operator stage,
    output var data_t     m_data
);

    data_t result;

    // ------------------------------
    // operation
    // ------------------------------

    always_comb begin
        if (stage.clear && stage.valid) begin
            result = '1;            // clear override
        end else begin
            result = ~stage.data;
        end
    end

    // ------------------------------
    // result pipeline
    // ------------------------------

    spu_delay #(
        .DEPTH     (LATENCY),
        .payload_t (data_t)
    ) u_result_delay (
        .clk      (clk),
        .reset    (reset),
        .cke      (stage.cke),
        .in_data  (result),
        .out_data (m_data)
    );

endmodule

`default_nettype wire

/* design/spu_pkg.sv */
`default_nettype none

package spu_pkg;

    // ------------------------------
    // default sizes
    // ------------------------------

    localparam int DEFAULT_DATA_BITS = 8;   // operand width
    localparam int DEFAULT_LATENCY   = 2;   // operator pipeline depth

    // ------------------------------
    // operation codes
    // ------------------------------

    // values 0 to 4 match the golden file encoding
    typedef enum logic [2:0] {
        op_not = 3'd0,  // ~a
        op_and = 3'd1,  // a & b
        op_or  = 3'd2,  // a | b
        op_xor = 3'd3,  // a ^ b
        op_add = 3'd4   // a + b wrapping at the data width
    } spu_op_t;

    // function select for the shared logic operator
    typedef enum logic [1:0] {
        fn_and = 2'd0,
        fn_or  = 2'd1,
        fn_xor = 2'd2
    } logic_fn_t;

    // clear value rule
    // a transfer with clear set returns all ones of the data width
    // whatever the operation

endpackage

`default_nettype wire

/* design/spu_stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

// operand stage to operator bundle
// one instance per operator so that valid can be steered
interface spu_stage_if #(
    parameter type data_t = logic [spu_pkg::DEFAULT_DATA_BITS-1:0]
) ();

    logic  cke;     // stage advance enable
    data_t data;    // operand a
    logic  clear;   // force result to all ones
    logic  valid;   // transfer aimed at this operator

    // operand stage side
    modport driver (
        output cke,
        output data,
        output clear,
        output valid
    );

    // operator side
    modport operator (
        input cke,
        input data,
        input clear,
        input valid
    );

endinterface

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_spu_alu -f sim.f -Mdir obj_dir -o tb_spu_alu

output=$(./obj_dir/tb_spu_alu +verilator+error+limit+100)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

/* sim.f */
design/spu_pkg.sv
design/spu_stage_if.sv
design/spu_delay.sv
design/spu_op_not.sv
design/spu_op_logic.sv
design/spu_op_add.sv
design/spu_alu_top.sv
testbench/spu_alu_properties.sv
testbench/tb_spu_alu.sv

/* testbench/spu_alu_golden.txt */
// one transfer per line, 8 hex digits: opcode(1) clear(1) a(2) b(2) expected(2)
// opcode 0 not, 1 and, 2 or, 3 xor, 4 add; clear set gives ff for any opcode
00005aff
00ff0000
003c11c3
00a5ff5a
0081007e
006e2291
10f03c30
10ffa5a5
1000ff00
105aa500
10c77e46
20f00fff
20000000
20124052
20a005a5
20881199
30ffff00
30aa55ff
303c0f33
3000c4c4
309669ff
40ff0100
40010203
40808000
407f0180
40fffffe
403a4781
40c8642c
01ff00ff
110000ff
211234ff
31ffffff
410101ff
40102030
000f00f0
30f0ff0f
11aabbff
20018081
40fe01ff
100ff000

/* testbench/spu_alu_properties.sv */
`timescale 1ns/1ps
`default_nettype none

// handshake and reset checks on the top level ports
module spu_alu_properties #(
    parameter int DATA_BITS = spu_pkg::DEFAULT_DATA_BITS
) (
    input var logic                 clk,
    input var logic                 reset,
    input var logic                 s_ready,
    input var logic                 m_valid,
    input var logic [DATA_BITS-1:0] m_data,
    input var logic                 m_ready
);

    int fail_count = 0;     // assertion failures so far

    // ------------------------------
    // reset
    // ------------------------------

    reset_empties_output: assert property (@(posedge clk) reset |=> !m_valid && s_ready)
        else begin
            $error("m_valid high or s_ready low in the cycle after reset");
            fail_count++;
        end

    // ------------------------------
    // handshake
    // ------------------------------

    stall_holds_output: assert property (@(posedge clk) disable iff (reset)
        m_valid && !m_ready |=> m_valid && $stable(m_data))
        else begin
            $error("output changed while stalled");
            fail_count++;
        end

    ready_tracks_stall: assert property (@(posedge clk) disable iff (reset)
        s_ready == !(m_valid && !m_ready))
        else begin
            $error("s_ready does not follow the output stall");
            fail_count++;
        end

endmodule

bind spu_alu_top spu_alu_properties #(
    .DATA_BITS (DATA_BITS)
) u_properties (
    .clk     (clk),
    .reset   (reset),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_ready (m_ready)
);

`default_nettype wire

/* testbench/tb_spu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spu_alu;

    import spu_pkg::*;

    localparam int DATA_BITS   = DEFAULT_DATA_BITS;
    localparam int LATENCY     = DEFAULT_LATENCY;
    localparam int NUM_ENTRIES = 40;
    localparam int TIMEOUT     = 200;   // cycles allowed per handshake

    logic                 clk;
    logic                 reset;
    logic                 s_valid;
    spu_op_t              s_op;
    logic                 s_clear;
    logic [DATA_BITS-1:0] s_a;
    logic [DATA_BITS-1:0] s_b;
    logic                 s_ready;
    logic                 m_valid;
    logic [DATA_BITS-1:0] m_data;
    logic                 m_ready;

    logic [31:0] golden [0:NUM_ENTRIES-1];  // op, clear, a, b, expected
    integer      seed;
    int          error_count;
    int          check_count;

    spu_alu_top #(
        .DATA_BITS (DATA_BITS),
        .LATENCY   (LATENCY)
    ) dut (
        .clk     (clk),
        .reset   (reset),
        .s_valid (s_valid),
        .s_op    (s_op),
        .s_clear (s_clear),
        .s_a     (s_a),
        .s_b     (s_b),
        .s_ready (s_ready),
        .m_valid (m_valid),
        .m_data  (m_data),
        .m_ready (m_ready)
    );

    always #4 clk = ~clk;

    // ------------------------------
    // helpers
    // ------------------------------

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    function automatic string op_label(input logic [3:0] op, input logic clr);
        string name;
        case (op)
            4'd0:    name = "not";
            4'd1:    name = "and";
            4'd2:    name = "or";
            4'd3:    name = "xor";
            4'd4:    name = "add";
            default: name = "unknown";
        endcase
        return clr ? {name, " clear"} : name;
    endfunction

    // ------------------------------
    // source side
    // ------------------------------

    task automatic drive_all();
        int          idx;
        int          cycles;
        bit          accepted;
        logic [31:0] entry;
        for (idx = 0; idx < NUM_ENTRIES; idx++) begin
            entry = golden[idx];
            @(posedge clk);
            #1;
            if (($random(seed) & 3) == 0) begin
                s_valid = 1'b0;     // one idle cycle
                @(posedge clk);
                #1;
            end
            s_valid  = 1'b1;
            s_op     = spu_op_t'(entry[30:28]);
            s_clear  = entry[24];
            s_a      = entry[23:16];
            s_b      = entry[15:8];
            accepted = 1'b0;
            cycles   = 0;
            while (!accepted && cycles < TIMEOUT) begin
                @(negedge clk);
                if (s_ready) accepted = 1'b1;   // taken at the next edge
                else cycles++;
            end
            if (!accepted) begin
                error_count++;
                $display("Error: entry %0d was never accepted, no input transfer", idx);
                return;
            end
        end
        @(posedge clk);
        #1;
        s_valid = 1'b0;
    endtask

    // ------------------------------
    // sink side
    // ------------------------------

    task automatic receive_all();
        int          idx;
        int          cycles;
        bit          got;
        logic [31:0] entry;
        for (idx = 0; idx < NUM_ENTRIES; idx++) begin
            entry  = golden[idx];
            got    = 1'b0;
            cycles = 0;
            while (!got && cycles < TIMEOUT) begin
                @(posedge clk);
                #1;
                m_ready = ($unsigned($random(seed)) % 3) != 0;  // low about 1 in 3
                @(negedge clk);
                if (m_valid && m_ready) got = 1'b1;
                else cycles++;
            end
            if (!got) begin
                error_count++;
                $display("Error: no result transfer for entry %0d", idx);
                return;
            end
            check_value($sformatf("entry %0d %s", idx, op_label(entry[31:28], entry[24])),
                        32'(entry[7:0]), 32'(m_data));
        end
        // nothing may follow the last result
        @(posedge clk);
        #1;
        m_ready = 1'b1;
        repeat (2 * LATENCY + 2) begin
            @(negedge clk);
            if (m_valid) begin
                error_count++;
                $display("Error: extra result seen after the last entry");
            end
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        s_valid     = 1'b0;
        s_op        = op_not;
        s_clear     = 1'b0;
        s_a         = '0;
        s_b         = '0;
        m_ready     = 1'b0;
        seed        = 38;
        error_count = 0;
        check_count = 0;
        $readmemh("testbench/spu_alu_golden.txt", golden);

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // idle outputs before any transfer
        repeat (3) begin
            @(negedge clk);
            check_value("reset m_valid", 32'd0, 32'(m_valid));
            check_value("reset s_ready", 32'd1, 32'(s_ready));
        end

        fork
            drive_all();
            receive_all();
        join

        error_count += dut.u_properties.fail_count;
        $display("errors: %0d, checks: %0d", error_count, check_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
